// ==== hdl/cpu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Core package
// Opcodes, instruction word, core states and core widths
// for the accumulator processor
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package cpu_pkg;

   // Program counter and operand width, 32 words of ROM
   localparam int pc_width = 5;

   // Accumulator and B register width
   localparam int acc_width = 8;

   // Startup delay, board clock settles in this time
   localparam int startup_cycles = 64;
   localparam int timer_width = $clog2(startup_cycles);   // 6 bits for 64

   // Terminal count of the startup timer
   localparam logic [timer_width-1:0] timer_last = timer_width'(startup_cycles - 1);

   // Instruction opcodes
   typedef enum logic [2:0] {
      op_ldi = 3'd0,   // acc = operand
      op_in  = 3'd1,   // acc = bus read data
      op_out = 3'd2,   // bus write of acc
      op_add = 3'd3,   // acc = acc + b
      op_xch = 3'd4,   // swap acc and b
      op_jmp = 3'd5    // pc = operand
   } opcode_e;

   // Instruction word, opcode in the top bits
   typedef struct packed {
      opcode_e               op;
      logic [pc_width-1:0]   operand;   // Immediate or jump target
   } instr_t;

   // Core sequencer states
   typedef enum logic [1:0] {
      st_idle,    // Waiting for start
      st_fetch,   // ROM read in progress
      st_exec,    // Decode and execute
      st_bus      // Bus cycle open until ack
   } core_state_e;

endpackage

`default_nettype wire

// ==== hdl/bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Bus package
// Classic Wishbone style master request and slave response
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package bus_pkg;

   // Data path width of the I/O bus
   localparam int data_width = 8;

   // Master side of the bus
   typedef struct packed {
      logic                    cyc;   // Cycle in progress
      logic                    stb;   // Strobe, valid transfer
      logic                    we;    // Write when high, read when low
      logic [data_width-1:0]   dat;   // Write data
   } bus_req_t;

   // Slave side of the bus
   typedef struct packed {
      logic                    ack;   // Transfer done
      logic [data_width-1:0]   dat;   // Read data, valid with ack
   } bus_rsp_t;

endpackage

`default_nettype wire

// ==== hdl/startup_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Startup timer
// Waits 64 cycles after reset, then gives the core
// a single start pulse
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module startup_timer (
   input  logic CLK_I,
   input  logic reset,
   output logic start
);

   logic [cpu_pkg::timer_width-1:0] cnt;   // Cycles since reset
   logic                            done;  // Delay elapsed
   logic                            last;  // Terminal count reached

   assign last = (cnt == cpu_pkg::timer_last);

   always_ff @(posedge CLK_I) begin
      if (reset) begin
         cnt   <= '0;
         done  <= 1'b0;
         start <= 1'b0;
      end else begin
         start <= last & ~done;        // High only in the cycle done sets
         if (!done) begin
            cnt <= cnt + 1'b1;
            if (last)
               done <= 1'b1;           // Counter frozen from here on
         end
      end
   end

endmodule

`default_nettype wire

// ==== hdl/prog_rom.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Program ROM
// Fixed counting program, read through an output register
// so the word arrives one cycle after the address
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module prog_rom (
   input  logic                         CLK_I,
   input  logic [cpu_pkg::pc_width-1:0] pc,
   output cpu_pkg::instr_t              instr
);

   cpu_pkg::instr_t rom_word;   // Table output before the register

   // Loop counts the cycles with the input pin high
   always_comb begin
      case (pc)
         5'd0:    rom_word = '{op: cpu_pkg::op_ldi, operand: 5'd0};   // acc = 0
         5'd1:    rom_word = '{op: cpu_pkg::op_xch, operand: 5'd0};   // b = 0
         5'd2:    rom_word = '{op: cpu_pkg::op_in,  operand: 5'd0};   // acc = pin
         5'd3:    rom_word = '{op: cpu_pkg::op_add, operand: 5'd0};   // acc = pin + b
         5'd4:    rom_word = '{op: cpu_pkg::op_out, operand: 5'd0};   // LEDs = sum
         5'd5:    rom_word = '{op: cpu_pkg::op_xch, operand: 5'd0};   // b = sum
         5'd6:    rom_word = '{op: cpu_pkg::op_jmp, operand: 5'd2};   // Back to the read
         default: rom_word = '{op: cpu_pkg::op_jmp, operand: 5'd2};   // Stray pc recovers
      endcase
   end

   // Block RAM style registered read
   always_ff @(posedge CLK_I) begin
      instr <= rom_word;
   end

endmodule

`default_nettype wire

// ==== hdl/accum_core.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Accumulator core
// Fetch and execute sequencer with accumulator, B register
// and program counter. I/O through a classic bus master,
// one instruction in flight
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module accum_core (
   input  logic                         CLK_I,
   input  logic                         reset,
   input  logic                         start,
   input  cpu_pkg::instr_t              instr,
   output logic [cpu_pkg::pc_width-1:0] pc,
   output bus_pkg::bus_req_t            bus_req,
   input  bus_pkg::bus_rsp_t            bus_rsp,
   output logic                         running
);

   cpu_pkg::core_state_e              state;
   logic [cpu_pkg::acc_width-1:0]     acc;       // Accumulator
   logic [cpu_pkg::acc_width-1:0]     b_reg;     // Second operand
   logic [cpu_pkg::acc_width-1:0]     operand_x; // Operand zero extended
   logic                              bus_op;    // Current opcode uses the bus
   logic                              req_on;    // Request driven this cycle
   logic                              exec_now;  // Non bus opcode retires
   logic                              bus_done;  // Bus opcode retires

   assign operand_x = {{(cpu_pkg::acc_width - cpu_pkg::pc_width){1'b0}}, instr.operand};

   // ROM holds the word while pc is unchanged, so op stays valid in st_bus
   assign bus_op = (instr.op == cpu_pkg::op_in) || (instr.op == cpu_pkg::op_out);

   assign exec_now = (state == cpu_pkg::st_exec) && !bus_op;
   assign bus_done = (state == cpu_pkg::st_bus) && bus_rsp.ack;

   // Request opens in st_exec and stays up through st_bus until ack
   assign req_on = ((state == cpu_pkg::st_exec) && bus_op) || (state == cpu_pkg::st_bus);

   always_comb begin
      bus_req.cyc = req_on;
      bus_req.stb = req_on;
      bus_req.we  = req_on && (instr.op == cpu_pkg::op_out);
      bus_req.dat = acc;                 // Steady, acc is not touched mid cycle
   end

   assign running = (state != cpu_pkg::st_idle);

   // Sequencer and program counter
   always_ff @(posedge CLK_I) begin
      if (reset) begin
         state <= cpu_pkg::st_idle;
         pc    <= '0;
      end else begin
         case (state)
            cpu_pkg::st_idle: begin
               if (start)
                  state <= cpu_pkg::st_fetch;
            end
            cpu_pkg::st_fetch: begin
               state <= cpu_pkg::st_exec;   // ROM word lands at this edge
            end
            cpu_pkg::st_exec: begin
               if (bus_op) begin
                  state <= cpu_pkg::st_bus;  // pc held, request held
               end else begin
                  state <= cpu_pkg::st_fetch;
                  if (instr.op == cpu_pkg::op_jmp)
                     pc <= instr.operand;
                  else
                     pc <= pc + 1'b1;
               end
            end
            cpu_pkg::st_bus: begin
               if (bus_rsp.ack) begin       // Otherwise wait, nothing moves
                  state <= cpu_pkg::st_fetch;
                  pc    <= pc + 1'b1;
               end
            end
            default: state <= cpu_pkg::st_idle;
         endcase
      end
   end

   // Datapath, program sets acc and b before use
   always_ff @(posedge CLK_I) begin
      if (exec_now) begin
         case (instr.op)
            cpu_pkg::op_ldi: acc <= operand_x;
            cpu_pkg::op_add: acc <= acc + b_reg;   // Wraps at 8 bits
            cpu_pkg::op_xch: begin
               acc   <= b_reg;
               b_reg <= acc;
            end
            default: ;                            // jmp leaves data alone
         endcase
      end
      // Read data taken with ack, second flop of the pin guard
      if (bus_done && (instr.op == cpu_pkg::op_in))
         acc <= bus_rsp.dat;
   end

endmodule

`default_nettype wire

// ==== hdl/board_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Board top
// Accumulator core with program ROM and startup timer,
// pin synchronizer, LED register and one flop acknowledge
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module board_top (
   input  logic CLK_I,
   input  logic reset,
   input  logic serial_rx,
   output logic led1,
   output logic led2,
   output logic led3,
   output logic led4
);

   logic                         rx_meta;   // Pin flop, first stage
   logic                         ack_q;     // Strobe delayed one cycle
   logic                         start;
   logic                         running;
   logic [cpu_pkg::pc_width-1:0] pc;
   cpu_pkg::instr_t              instr;
   bus_pkg::bus_req_t            bus_req;
   bus_pkg::bus_rsp_t            bus_rsp;

   // Async pin into the I/O flop, core capture is the second stage
   always_ff @(posedge CLK_I) begin
      rx_meta <= serial_rx;
   end

   // No decode, every write lands on the LEDs
   always_ff @(posedge CLK_I) begin
      if (reset) begin
         led1 <= 1'b0;
         led2 <= 1'b0;
         led3 <= 1'b0;
         led4 <= 1'b0;
      end else begin
         if (bus_req.cyc && bus_req.stb && bus_req.we) begin
            led1 <= bus_req.dat[0];
            led2 <= bus_req.dat[1];
            led3 <= bus_req.dat[2];
         end
         led4 <= running;   // Core alive indicator
      end
   end

   always_ff @(posedge CLK_I) begin
      if (reset)
         ack_q <= 1'b0;
      else
         ack_q <= bus_req.stb;
   end

   // Every read returns the pin in bit 0
   always_comb begin
      bus_rsp.ack = ack_q;
      bus_rsp.dat = {{(bus_pkg::data_width - 1){1'b0}}, rx_meta};
   end

   startup_timer i_startup_timer (
      .CLK_I (CLK_I),
      .reset (reset),
      .start (start)
   );

   prog_rom i_prog_rom (
      .CLK_I (CLK_I),
      .pc    (pc),
      .instr (instr)
   );

   accum_core i_accum_core (
      .CLK_I   (CLK_I),
      .reset   (reset),
      .start   (start),
      .instr   (instr),
      .pc      (pc),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp),
      .running (running)
   );

endmodule

`default_nettype wire

// ==== dv/tb_board_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Board top testbench
// Startup delay, idle pin, steady count and random pin
// segments, checked against a counting model on the LEDs
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_board_top;
   timeunit 1ns;
   timeprecision 100ps;

   logic        CLK_I;
   logic        reset;
   logic        serial_rx;
   logic        led1;
   logic        led2;
   logic        led3;
   logic        led4;

   logic [2:0]  prev_leds;       // Last LED count seen by the checker
   logic        hold_leds;       // Any LED change is an error while set
   logic        led4_expected;   // Core seen running, led4 must stay up
   logic [15:0] lfsr_state;
   int          change_count;    // LED changes since time 0
   int          error_count;
   int          tests_run;
   int          tests_failed;
   int          errors_before;
   int          seg;

   board_top i_dut (
      .CLK_I     (CLK_I),
      .reset     (reset),
      .serial_rx (serial_rx),
      .led1      (led1),
      .led2      (led2),
      .led3      (led3),
      .led4      (led4)
   );

   initial begin
      CLK_I = 1'b0;
      forever #4 CLK_I = ~CLK_I;   // 125 MHz
   end

   // Expected LED count after one more high sample
   function automatic logic [2:0] next_count(input logic [2:0] prev);
      next_count = 3'((int'(prev) + 1) % 8);
   endfunction

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // LED checker, samples on the falling edge where outputs are stable
   initial begin
      forever begin
         @(negedge CLK_I);
         if (reset) begin
            prev_leds     = 3'd0;   // LEDs clear with reset
            led4_expected = 1'b0;
         end else begin
            if ({led3, led2, led1} != prev_leds) begin
               change_count++;
               if (hold_leds) begin
                  $display("mismatch at %0t: leds expected %0d, got %0d",
                           $time, prev_leds, {led3, led2, led1});
                  error_count++;
               end else if ({led3, led2, led1} != next_count(prev_leds)) begin
                  $display("mismatch at %0t: leds expected %0d, got %0d",
                           $time, next_count(prev_leds), {led3, led2, led1});
                  error_count++;
               end
               prev_leds = {led3, led2, led1};
            end
            if (led4_expected && !led4) begin
               $display("mismatch at %0t: led4 expected 1, got 0", $time);
               error_count++;
               led4_expected = 1'b0;   // Report the drop once
            end
         end
      end
   end

   task automatic apply_reset();
      @(posedge CLK_I);
      reset <= 1'b1;
      repeat (4) @(posedge CLK_I);
      reset <= 1'b0;
   endtask

   // All LEDs low, led4 low for 60 cycles, then high within 100
   task automatic check_startup();
      int cycles;
      @(negedge CLK_I);
      if ({led4, led3, led2, led1} != 4'd0) begin
         $display("mismatch at %0t: leds expected 0, got %0d",
                  $time, {led4, led3, led2, led1});
         error_count++;
      end
      for (cycles = 1; cycles < 60; cycles++) begin
         @(negedge CLK_I);
         if (led4) begin
            $display("mismatch at %0t: led4 expected 0, got 1", $time);
            error_count++;
         end
      end
      cycles = 0;
      while (!led4 && cycles < 100) begin
         @(negedge CLK_I);
         cycles++;
      end
      if (led4) begin
         led4_expected = 1'b1;
      end else begin
         $display("timeout at %0t: led4 did not go high within 100 cycles", $time);
         error_count++;
      end
   endtask

   // Checker counts on the falling edge, polled here on the rising edge
   task automatic wait_led_change(input int limit);
      int start_count;
      int cycles;
      start_count = change_count;
      cycles      = 0;
      while (change_count == start_count && cycles < limit) begin
         @(posedge CLK_I);
         cycles++;
      end
      if (change_count == start_count) begin
         $display("timeout at %0t: no LED change within %0d cycles", $time, limit);
         error_count++;
      end
   endtask

   task automatic finish_test(input string name, input int errors_at_start);
      tests_run++;
      if (error_count == errors_at_start) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed, %0d errors", name, error_count - errors_at_start);
      end
   endtask

   initial begin
      reset         = 1'b1;
      serial_rx     = 1'b0;
      prev_leds     = 3'd0;
      hold_leds     = 1'b0;
      led4_expected = 1'b0;
      lfsr_state    = 16'd7842;
      change_count  = 0;
      error_count   = 0;
      tests_run     = 0;
      tests_failed  = 0;

      errors_before = error_count;
      apply_reset();
      check_startup();
      finish_test("1 startup delay", errors_before);

      // Pin low, count must stay at 0
      errors_before = error_count;
      @(posedge CLK_I);
      serial_rx <= 1'b0;
      hold_leds = 1'b1;
      repeat (200) @(posedge CLK_I);
      hold_leds = 1'b0;
      finish_test("2 pin low", errors_before);

      // Pin high, 16 steps wrap the count twice
      errors_before = error_count;
      @(posedge CLK_I);
      serial_rx <= 1'b1;
      repeat (16) wait_led_change(60);
      finish_test("3 pin high", errors_before);

      errors_before = error_count;
      for (seg = 0; seg < 12; seg++) begin
         lfsr_state = lfsr_next(lfsr_state);
         @(posedge CLK_I);
         serial_rx <= lfsr_state[0];
         repeat (10) @(posedge CLK_I);   // Loop in flight may still write
         hold_leds = !lfsr_state[0];
         repeat (30) @(posedge CLK_I);
         hold_leds = 1'b0;
      end
      finish_test("4 random pin", errors_before);

      // Reset in mid count
      errors_before = error_count;
      @(posedge CLK_I);
      serial_rx <= 1'b1;
      wait_led_change(60);
      if (prev_leds == 3'd0)
         wait_led_change(60);   // Reset must land on a nonzero count
      apply_reset();
      check_startup();
      finish_test("5 second reset", errors_before);

      $display("tests run %0d, failed %0d, errors %0d, led changes %0d",
               tests_run, tests_failed, error_count, change_count);
      if (error_count == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/cpu_pkg.sv
hdl/bus_pkg.sv
hdl/startup_timer.sv
hdl/prog_rom.sv
hdl/accum_core.sv
hdl/board_top.sv
dv/tb_board_top.sv

// ==== Makefile ====
# Verilator simulation of the board top
TOP := tb_board_top

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
